/* dv/spiStimulus.txt */
// Columns: divider, transmit byte, slave reply byte, chip-select level (hex)
// One transfer per line, chip select 0 leaves the slave deselected
0000 a5 3c 1
0001 5a c3 1
0002 ff 00 1
0003 00 ff 1
0001 81 7e 0
0007 3c 96 1
0000 e7 18 1
0004 12 34 0
0002 c9 6b 1

/* tb.f */
+incdir+logic
logic/spiBusPkg.sv
logic/spiCorePkg.sv
logic/spiCsr.sv
logic/spiClkGen.sv
logic/spiShifter.sv
logic/spiCtrl.sv
logic/spiBlock.sv
dv/spiBlockTb.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the SPI block testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module spiBlockTb -o spiBlockSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/spiBlockSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

/* dv/spiBlockTb.sv */
// --------------------
// SPI block testbench
// File-driven transfers against a mode 0 slave model
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "spiBlock_defs.svh"

module spiBlockTb
	import spiBusPkg::*, spiCorePkg::*;
();

	typedef struct packed {
		logic [`SPI_DIV_WIDTH-1:0] div;
		logic [7:0]                tx;
		logic [7:0]                reply;          // Slave answer on miso
		logic                      cs;
	} stimVec_t;

	localparam int STIM_WORDS = 64;                 // Four words per line

	logic        sysClk = 1'b0;
	logic        arstN;
	usiWrite_t   usiWr;
	usiRead_t    usiRd;
	usiRsp_t     usiRsp;
	spiPins_t    pins;
	logic        miso;
	logic        intr;

	logic [15:0] stimMem [0:STIM_WORDS-1];
	stimVec_t    vecQ [$];
	int          valErrs = 0;
	int          otherErrs = 0;
	int          timeoutLimit = 0;
	logic [7:0]  slaveReply;
	logic [7:0]  lastRx;                            // Expected RXD contents
	logic [7:0]  expMosi;

	spiBlock DUT (
		.sysClk (sysClk), .arstN (arstN),
		.usiWr  (usiWr),  .usiRd (usiRd), .usiRsp (usiRsp),
		.pins   (pins),   .miso  (miso),  .intr   (intr)
	);

	always #20 sysClk = ~sysClk;                    // 40 ns period

	// --------------------
	// Slave model
	// --------------------
	logic [2:0] slaveBit = 3'd0;                    // Wraps after each byte
	logic [7:0] mosiCap = 8'h00;

	// Deselected slave leaves miso pulled high
	assign miso = pins.csN ? 1'b1 : slaveReply[3'd7 - slaveBit];

	always @(negedge pins.sck)
	begin
		if (!pins.csN)
			slaveBit <= slaveBit + 3'd1;            // Next bit after each fall
	end

	always @(posedge pins.sck)
	begin
		if (!pins.csN)
			mosiCap <= {mosiCap[6:0], pins.mosi};
	end

	// --------------------
	// Clock edge monitor
	// --------------------
	int   cycleCnt = 0;
	int   intrCnt = 0;
	int   sckEdges = 0;
	int   sinceEdge = 0;
	int   halfIdx = 0;
	int   lastHalfCnt = 0;                          // Intervals in the last byte
	int   halfLog [0:15];
	logic sckPrev = 1'b0;
	logic edgeSeen = 1'b0;

	always @(posedge sysClk)
	begin
		cycleCnt = cycleCnt + 1;
		if (arstN)
		begin
			if (pins.sck != sckPrev)
			begin
				sckEdges = sckEdges + 1;
				if (edgeSeen && halfIdx < 16)
				begin
					halfLog[halfIdx] = sinceEdge;   // Cycles since previous edge
					halfIdx = halfIdx + 1;
				end
				edgeSeen = 1'b1;
				sinceEdge = 1;
			end
			else
				sinceEdge = sinceEdge + 1;
			if (intr)
			begin
				intrCnt = intrCnt + 1;
				lastHalfCnt = halfIdx;
				halfIdx = 0;
				edgeSeen = 1'b0;
			end
			sckPrev = pins.sck;
		end
	end

	always @(negedge sysClk)
	begin
		if (timeoutLimit > 0 && cycleCnt > timeoutLimit)
		begin
			$display("Timeout: no finish within %0d cycles, %0d value errors, %0d other errors",
				timeoutLimit, valErrs, otherErrs);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// --------------------
	// Compare tasks
	// --------------------
	task automatic checkWord(input string name, input usiRsp_t exp, input usiRsp_t act);
		if (act !== exp)
		begin
			valErrs++;
			$display("Error %s: expected %h/%b, actual %h/%b", name, exp.rdData, exp.rdEn,
				act.rdData, act.rdEn);
		end
	endtask

	task automatic checkByte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			valErrs++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic checkPins(input string name, input spiPins_t exp, input spiPins_t act);
		if (act !== exp)
		begin
			valErrs++;
			$display("Error %s: expected sck/mosi/csN %b, actual %b", name, exp, act);
		end
	endtask

	task automatic checkCount(input string name, input int exp, input int act);
		if (act != exp)
		begin
			valErrs++;
			$display("Error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// --------------------
	// Bus helpers
	// --------------------
	function automatic logic [15:0] blockAdrs(input logic [7:0] offset);
		return {`SPI_BLOCK_ADRS, offset};
	endfunction

	function automatic usiRsp_t rspWord(input logic [31:0] data);
		return {data, 1'b1};
	endfunction

	function automatic spiPins_t pinLevels(input logic sck, input logic mosi, input logic csN);
		return {sck, mosi, csN};
	endfunction

	function automatic csrWord_u ctrlWord(input logic en, input logic cs);
		csrWord_u w;
		w.ctrlView.rsvd = '1;                       // Must not stick
		w.ctrlView.cs = cs;
		w.ctrlView.en = en;
		return w;
	endfunction

	function automatic csrWord_u divWord(input logic [`SPI_DIV_WIDTH-1:0] div);
		csrWord_u w;
		w.divView.rsvd = '1;
		w.divView.div = div;
		return w;
	endfunction

	// Classic C library LCG step
	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic busWrite(input logic [15:0] adrs, input csrWord_u word);
		@(posedge sysClk);
		usiWr.data <= word;
		usiWr.adrs <= adrs;
		usiWr.wrStb <= 1'b1;
		@(posedge sysClk);                          // Taken on this edge
		usiWr.wrStb <= 1'b0;
	endtask

	// Response must show up exactly one cycle after the strobe edge
	task automatic readCheck(input string name, input logic [15:0] adrs, input usiRsp_t exp);
		@(posedge sysClk);
		usiRd.adrs <= adrs;
		usiRd.rdStb <= 1'b1;
		@(negedge sysClk);
		if (usiRsp.rdEn)
		begin
			otherErrs++;
			$display("%s: read enable rose before the strobe was taken", name);
		end
		@(posedge sysClk);
		usiRd.rdStb <= 1'b0;
		@(negedge sysClk);
		checkWord(name, exp, usiRsp);
		@(negedge sysClk);
		if (usiRsp.rdEn)
		begin
			otherErrs++;
			$display("%s: read enable stayed high for more than one cycle", name);
		end
	endtask

	task automatic expectNoRead(input logic [15:0] adrs);
		@(posedge sysClk);
		usiRd.adrs <= adrs;
		usiRd.rdStb <= 1'b1;
		@(posedge sysClk);
		usiRd.rdStb <= 1'b0;
		repeat (3)
		begin
			@(negedge sysClk);
			if (usiRsp.rdEn)
			begin
				otherErrs++;
				$display("A read of another block address got a response");
			end
		end
	endtask

	task automatic waitForIntr();
		@(negedge sysClk);
		while (!intr)
			@(negedge sysClk);                      // Bounded by the timeout
	endtask

	// --------------------
	// Transfer tests
	// --------------------
	task automatic runTransfer(input stimVec_t v, input int idx);
		logic [7:0] expRx;
		int         startIntr;
		expRx = v.cs ? v.reply : 8'hFF;
		busWrite(blockAdrs(`SPI_ADRS_DIV), divWord(v.div));
		busWrite(blockAdrs(`SPI_ADRS_CTRL), ctrlWord(1'b1, v.cs));
		@(negedge sysClk);
		checkPins($sformatf("vector %0d idle pins", idx), pinLevels(1'b0, 1'b0, ~v.cs), pins);
		slaveReply = v.reply;
		startIntr = intrCnt;
		busWrite(blockAdrs(`SPI_ADRS_TXD), csrWord_u'({24'd0, v.tx}));
		waitForIntr();
		readCheck($sformatf("vector %0d rxd", idx), blockAdrs(`SPI_ADRS_RXD),
			rspWord({23'd0, 1'b0, expRx}));
		if (v.cs)
			expMosi = v.tx;                         // Slave only sees bits when selected
		checkByte($sformatf("vector %0d mosi", idx), expMosi, mosiCap);
		checkCount($sformatf("vector %0d intr pulses", idx), 1, intrCnt - startIntr);
		checkCount($sformatf("vector %0d sck intervals", idx), 15, lastHalfCnt);
		for (int i = 0; i < 15; i++)
			checkCount($sformatf("vector %0d sck half period %0d", idx, i),
				int'(v.div) + 1, halfLog[i]);
		lastRx = expRx;
	endtask

	task automatic busyAndDrop();
		int startIntr;
		int startEdges;
		busWrite(blockAdrs(`SPI_ADRS_DIV), divWord(16'd3));
		busWrite(blockAdrs(`SPI_ADRS_CTRL), ctrlWord(1'b1, 1'b1));
		slaveReply = 8'h96;
		startIntr = intrCnt;
		busWrite(blockAdrs(`SPI_ADRS_TXD), csrWord_u'(32'h5A));
		readCheck("rxd busy mid transfer", blockAdrs(`SPI_ADRS_RXD),
			rspWord({23'd0, 1'b1, lastRx}));
		busWrite(blockAdrs(`SPI_ADRS_TXD), csrWord_u'(32'hC3));   // Dropped
		waitForIntr();
		repeat (16 * 4 + 8)
			@(negedge sysClk);                      // Room for a wrong second byte
		checkCount("intr pulses with dropped write", 1, intrCnt - startIntr);
		expMosi = 8'h5A;
		checkByte("mosi with dropped write", expMosi, mosiCap);
		readCheck("rxd after busy transfer", blockAdrs(`SPI_ADRS_RXD),
			rspWord({23'd0, 1'b0, 8'h96}));
		// Disabled block must ignore TXD
		busWrite(blockAdrs(`SPI_ADRS_CTRL), ctrlWord(1'b0, 1'b1));
		startIntr = intrCnt;
		startEdges = sckEdges;
		busWrite(blockAdrs(`SPI_ADRS_TXD), csrWord_u'(32'h77));
		repeat (2 * 16 * 4)
			@(negedge sysClk);
		checkCount("sck edges while disabled", startEdges, sckEdges);
		checkCount("intr pulses while disabled", 0, intrCnt - startIntr);
	endtask

	// --------------------
	// Main flow
	// --------------------
	initial
	begin
		stimVec_t    v;
		logic [31:0] seed;
		int          budget;
		usiWr = '0;
		usiRd = '0;
		arstN = 1'b0;
		slaveReply = 8'h00;
		lastRx = 8'h00;
		expMosi = 8'h00;
		for (int a = 0; a < STIM_WORDS; a++)
			stimMem[a] = 16'hE000 | 16'(a);         // Unread lines fail the cs test
		$readmemh("dv/spiStimulus.txt", stimMem);
		for (int i = 0; i < STIM_WORDS / 4 && stimMem[4 * i + 3] <= 16'd1; i++)
		begin
			v.div = stimMem[4 * i];
			v.tx = stimMem[4 * i + 1][7:0];
			v.reply = stimMem[4 * i + 2][7:0];
			v.cs = stimMem[4 * i + 3][0];
			vecQ.push_back(v);
		end
		if (vecQ.size() == 0)
		begin
			otherErrs++;
			$display("No vectors could be read from the stimulus file");
		end
		seed = 32'd81101;
		repeat (4)
		begin
			seed = nextRandom(seed);
			v.div = {14'd0, seed[17:16]};
			seed = nextRandom(seed);
			v.tx = seed[23:16];
			v.reply = seed[31:24];
			v.cs = 1'b1;
			vecQ.push_back(v);
		end
		budget = 3 * (16 * 4 + 40);                 // Busy, drop and disabled phases
		foreach (vecQ[k])
			budget += 16 * (int'(vecQ[k].div) + 1) + 40;
		timeoutLimit = 2 * budget;

		repeat (16)
			@(posedge sysClk);
		arstN <= 1'b1;
		@(negedge sysClk);
		checkPins("pins after reset", pinLevels(1'b0, 1'b0, 1'b1), pins);
		checkCount("intr after reset", 0, int'(intr));
		readCheck("ctrl after reset", blockAdrs(`SPI_ADRS_CTRL), rspWord(32'd0));
		readCheck("div after reset", blockAdrs(`SPI_ADRS_DIV), rspWord(32'd0));

		// Readback through both union views
		busWrite(blockAdrs(`SPI_ADRS_CTRL), ctrlWord(1'b1, 1'b0));
		readCheck("ctrl en only", blockAdrs(`SPI_ADRS_CTRL), rspWord({30'd0, 1'b0, 1'b1}));
		busWrite(blockAdrs(`SPI_ADRS_CTRL), ctrlWord(1'b0, 1'b1));
		readCheck("ctrl cs only", blockAdrs(`SPI_ADRS_CTRL), rspWord({30'd0, 1'b1, 1'b0}));
		checkPins("csN with cs set", pinLevels(1'b0, 1'b0, 1'b0), pins);
		busWrite(blockAdrs(`SPI_ADRS_DIV), divWord(16'hBEEF));
		readCheck("div readback", blockAdrs(`SPI_ADRS_DIV), rspWord(32'h0000BEEF));
		busWrite({8'h05, `SPI_ADRS_DIV}, divWord(16'h1234));     // Other block
		readCheck("div after foreign write", blockAdrs(`SPI_ADRS_DIV), rspWord(32'h0000BEEF));
		expectNoRead({8'h05, `SPI_ADRS_CTRL});
		busWrite(blockAdrs(`SPI_ADRS_CTRL), ctrlWord(1'b0, 1'b0));

		foreach (vecQ[k])
			runTransfer(vecQ[k], k);
		busyAndDrop();

		$display("Error count: %0d value mismatches, %0d other failures", valErrs, otherErrs);
		if (valErrs + otherErrs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/spiBlock.sv */
// --------------------
// SPI master block
// CSR slave on the Usi bus driving an 8-bit mode 0 master
// --------------------
`timescale 1ns/1ps
`default_nettype none

module spiBlock
	import spiBusPkg::*, spiCorePkg::*;
(
	input  logic      sysClk,
	input  logic      arstN,
	input  usiWrite_t usiWr,
	input  usiRead_t  usiRd,
	output usiRsp_t   usiRsp,
	output spiPins_t  pins,
	input  logic      miso,
	output logic      intr                      // End of byte
);

	// --------------------
	// Internal nets
	// --------------------
	spiCfg_t    cfg;
	logic       start;
	logic [7:0] txByte;
	logic [7:0] rxByte;
	logic       busy;
	logic       done;
	logic       run;
	logic       load;
	logic       riseTick;
	logic       fallTick;
	logic       sck;
	logic       mosi;
	logic       csN;

	// Registers and bus slave
	spiCsr csr (
		.sysClk (sysClk),   .arstN  (arstN),
		.usiWr  (usiWr),    .usiRd  (usiRd),    .usiRsp (usiRsp),
		.cfg    (cfg),      .start  (start),    .txByte (txByte),
		.busy   (busy),     .done   (done),     .rxByte (rxByte),
		.csN    (csN)
	);

	// Sequencer
	spiCtrl ctrl (
		.sysClk   (sysClk),   .arstN    (arstN),
		.start    (start),    .cfg      (cfg),
		.riseTick (riseTick), .fallTick (fallTick),
		.run      (run),      .load     (load),
		.done     (done),     .busy     (busy),     .intr (intr)
	);

	// SCK divider
	spiClkGen clkGen (
		.sysClk   (sysClk),   .arstN    (arstN),
		.cfg      (cfg),      .run      (run),
		.sck      (sck),      .riseTick (riseTick), .fallTick (fallTick)
	);

	// Datapath
	spiShifter shifter (
		.sysClk   (sysClk),   .arstN    (arstN),
		.load     (load),     .txByte   (txByte),
		.riseTick (riseTick), .fallTick (fallTick),
		.miso     (miso),     .mosi     (mosi),     .rxByte (rxByte)
	);

	// Pin bundle
	assign pins.sck  = sck;
	assign pins.mosi = mosi;
	assign pins.csN  = csN;

endmodule

`default_nettype wire

/* logic/spiCtrl.sv */
// --------------------
// SPI transfer sequencer
// Counts eight SCK falls, then flags done and intr
// --------------------
`timescale 1ns/1ps
`default_nettype none

module spiCtrl
	import spiCorePkg::*;
(
	input  logic    sysClk,
	input  logic    arstN,
	input  logic    start,
	input  spiCfg_t cfg,
	input  logic    riseTick,
	input  logic    fallTick,
	output logic    run,                        // Clock generator active
	output logic    load,                       // Shifter load strobe
	output logic    done,
	output logic    busy,
	output logic    intr
);

	spiState_e state;
	spiState_e stateNext;
	logic [2:0] bitCnt;                         // Falls seen in this byte
	logic       lastFall;

	assign lastFall = fallTick && (bitCnt == 3'd7);
	assign load     = (state == IDLE) && start && cfg.en;

	// --------------------
	// Next state
	// --------------------
	always_comb
	begin
		stateNext = state;
		case (state)
			IDLE:    if (load) stateNext = SHIFT;
			SHIFT:   if (lastFall) stateNext = DONE;   // Eighth fall
			DONE:    stateNext = IDLE;
			default: stateNext = IDLE;
		endcase
	end

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			state <= IDLE;
		else
			state <= stateNext;
	end

	// --------------------
	// Bit counter
	// --------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			bitCnt <= '0;
		else if (load)
			bitCnt <= '0;
		else if (fallTick)
			bitCnt <= bitCnt + 1'b1;
	end

	// --------------------
	// Outputs
	// --------------------
	assign run  = (state == SHIFT);
	assign busy = (state == SHIFT);             // Drops with the done cycle
	assign done = (state == DONE);
	assign intr = (state == DONE);              // Single cycle interrupt

	// End marker never stretches
	assert property (@(posedge sysClk) disable iff (!arstN) done |=> !done)
		else $error("done held longer than one cycle");

	// Clock generator must be quiet while idle
	assert property (@(posedge sysClk) disable iff (!arstN)
		(state == IDLE) |-> !(riseTick || fallTick))
		else $error("SCK tick while sequencer idle");

endmodule

`default_nettype wire

/* logic/spiShifter.sv */
// --------------------
// SPI byte shifter
// MSB first out on mosi, sampled in from miso
// --------------------
`timescale 1ns/1ps
`default_nettype none

module spiShifter
(
	input  logic       sysClk,
	input  logic       arstN,
	input  logic       load,                    // Copy txByte in
	input  logic [7:0] txByte,
	input  logic       riseTick,
	input  logic       fallTick,
	input  logic       miso,
	output logic       mosi,
	output logic [7:0] rxByte
);

	logic [7:0] txShift;
	logic [7:0] rxShift;

	// --------------------
	// Transmit side
	// --------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			txShift <= '0;                      // mosi low out of reset
		else if (load)
			txShift <= txByte;
		else if (fallTick)
			txShift <= {txShift[6:0], 1'b0};    // Next bit after each fall
	end

	// Bit 7 is the one on the wire
	assign mosi = txShift[7];

	// --------------------
	// Receive side
	// --------------------
	// Slave changes miso on falls, so it is stable here
	always_ff @(posedge sysClk)
	begin
		if (riseTick)
			rxShift <= {rxShift[6:0], miso};
	end

	// Complete after the eighth rise
	assign rxByte = rxShift;

endmodule

`default_nettype wire

/* logic/spiClkGen.sv */
// --------------------
// SPI clock generator
// Mode 0 SCK with rise and fall ticks
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "spiBlock_defs.svh"

module spiClkGen
	import spiCorePkg::*;
(
	input  logic    sysClk,
	input  logic    arstN,
	input  spiCfg_t cfg,
	input  logic    run,                        // Count only during a transfer
	output logic    sck,
	output logic    riseTick,                   // SCK rises at end of this cycle
	output logic    fallTick                    // SCK falls at end of this cycle
);

	logic [`SPI_DIV_WIDTH-1:0] cnt;             // Cycles into current half period
	logic                      halfEnd;

	// Compare with >= so a smaller divider mid-byte cannot wrap the count
	assign halfEnd = run && (cnt >= cfg.div);

	// --------------------
	// Half period counter
	// --------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			cnt <= '0;
			sck <= 1'b0;
		end
		else if (!run)
		begin
			cnt <= '0;                          // Restart clean on next byte
			sck <= 1'b0;                        // Idle low
		end
		else if (halfEnd)
		begin
			cnt <= '0;
			sck <= ~sck;
		end
		else
			cnt <= cnt + 1'b1;
	end

	// Ticks lead the toggle by the edge they name
	assign riseTick = halfEnd && !sck;
	assign fallTick = halfEnd && sck;

endmodule

`default_nettype wire

/* logic/spiCsr.sv */
// --------------------
// SPI control and status registers
// Usi bus slave with start pulse and receive capture
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "spiBlock_defs.svh"

module spiCsr
	import spiBusPkg::*, spiCorePkg::*;
(
	input  logic      sysClk,
	input  logic      arstN,
	input  usiWrite_t usiWr,
	input  usiRead_t  usiRd,
	output usiRsp_t   usiRsp,
	output spiCfg_t   cfg,
	output logic      start,                    // One cycle transfer request
	output logic [7:0] txByte,
	input  logic      busy,
	input  logic      done,                     // Byte finished with rxByte valid
	input  logic [7:0] rxByte,
	output logic      csN
);

	// --------------------
	// Address decode
	// --------------------
	logic     wrHit;
	logic     rdHit;
	logic     txAccept;
	csrWord_u wrWord;
	csrWord_u rdWord;
	logic [7:0] rxData;

	assign wrHit = usiWr.wrStb && (usiWr.adrs[`SPI_BUS_ADRS_WIDTH-1:8] == `SPI_BLOCK_ADRS);
	assign rdHit = usiRd.rdStb && (usiRd.adrs[`SPI_BUS_ADRS_WIDTH-1:8] == `SPI_BLOCK_ADRS);
	assign wrWord = usiWr.data;

	// TXD only taken when enabled and nothing in flight
	assign txAccept = wrHit && (usiWr.adrs[7:0] == `SPI_ADRS_TXD)
		&& cfg.en && !busy && !start;

	// --------------------
	// Register writes
	// --------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			cfg    <= '0;
			start  <= 1'b0;
			rxData <= '0;
		end
		else
		begin
			start <= txAccept;                  // Pulse the cycle after the write
			if (wrHit && (usiWr.adrs[7:0] == `SPI_ADRS_CTRL))
			begin
				cfg.en <= wrWord.ctrlView.en;
				cfg.cs <= wrWord.ctrlView.cs;
			end
			if (wrHit && (usiWr.adrs[7:0] == `SPI_ADRS_DIV))
				cfg.div <= wrWord.divView.div;
			if (done)
				rxData <= rxByte;               // Readable from next cycle
		end
	end

	// Transmit byte held for the load pulse
	always_ff @(posedge sysClk)
	begin
		if (txAccept)
			txByte <= usiWr.data[7:0];
	end

	// Pin level straight from the stored bit
	assign csN = ~cfg.cs;

	// --------------------
	// Read path
	// --------------------
	always_comb
	begin
		rdWord = '0;
		case (usiRd.adrs[7:0])
			`SPI_ADRS_CTRL:
			begin
				rdWord.ctrlView.en = cfg.en;
				rdWord.ctrlView.cs = cfg.cs;
			end
			`SPI_ADRS_DIV: rdWord.divView.div = cfg.div;
			`SPI_ADRS_TXD: rdWord[7:0] = txByte;
			`SPI_ADRS_RXD:
			begin
				rdWord[7:0]               = rxData;
				rdWord[`SPI_RXD_BUSY_BIT] = busy;
			end
			default: rdWord = '0;       // Unmapped offset reads zero
		endcase
	end

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			usiRsp <= '0;
		else
		begin
			usiRsp.rdEn <= rdHit;               // Exactly one cycle after strobe
			if (rdHit)
				usiRsp.rdData <= rdWord;
		end
	end

	// Sequencer must be idle whenever a start is issued
	assert property (@(posedge sysClk) disable iff (!arstN) start |-> !busy)
		else $error("start issued while transfer busy");

endmodule

`default_nettype wire

/* logic/spiCorePkg.sv */
// --------------------
// SPI core types
// Configuration, pin bundle and sequencer states
// --------------------
`default_nettype none

package spiCorePkg;

`include "spiBlock_defs.svh"

	// --------------------
	// Configuration from CSR
	// --------------------
	typedef struct packed {
		logic                      en;          // Transfers allowed
		logic                      cs;          // Chip select asserted when high
		logic [`SPI_DIV_WIDTH-1:0] div;         // SCK half period is div+1 cycles
	} spiCfg_t;

	// --------------------
	// External SPI outputs
	// --------------------
	typedef struct packed {
		logic sck;                              // Mode 0, idles low
		logic mosi;                             // MSB first
		logic csN;                              // Active low select
	} spiPins_t;

	// --------------------
	// Transfer sequencer
	// --------------------
	typedef enum logic [1:0] {
		IDLE  = 2'd0,                           // Waiting for start
		SHIFT = 2'd1,                           // Clocking eight bits
		DONE  = 2'd2                            // One cycle end marker
	} spiState_e;

endpackage

`default_nettype wire

/* logic/spiBusPkg.sv */
// --------------------
// Usi register bus types for the SPI block
// --------------------
`default_nettype none

package spiBusPkg;

`include "spiBlock_defs.svh"

	// Write request from the bus master
	typedef struct packed {
		logic [31:0]                    data;   // Write data
		logic [`SPI_BUS_ADRS_WIDTH-1:0] adrs;   // Block and register address
		logic                           wrStb;  // Single cycle write strobe
	} usiWrite_t;

	// Read request from the bus master
	typedef struct packed {
		logic [`SPI_BUS_ADRS_WIDTH-1:0] adrs;
		logic                           rdStb;  // Single cycle read strobe
	} usiRead_t;

	// Read response, valid while rdEn is high
	typedef struct packed {
		logic [31:0] rdData;
		logic        rdEn;
	} usiRsp_t;

	// One CSR word seen two ways, picked by register offset
	typedef union packed {
		struct packed {
			logic [29:0] rsvd;
			logic        cs;                    // Chip select level
			logic        en;                    // Block enable
		} ctrlView;
		struct packed {
			logic [31-`SPI_DIV_WIDTH:0] rsvd;
			logic [`SPI_DIV_WIDTH-1:0]  div;    // Half period minus one
		} divView;
	} csrWord_u;

endpackage

`default_nettype wire

/* logic/spiBlock_defs.svh */
// --------------------
// SPI block constants
// Bus address map, register offsets and field widths
// --------------------
`ifndef SPI_BLOCK_DEFS_SVH
`define SPI_BLOCK_DEFS_SVH

// --------------------
// Bus side
// --------------------
`define SPI_BUS_ADRS_WIDTH 16               // Usi bus address width
`define SPI_BLOCK_ADRS     8'h03            // Block select in adrs[15:8]

// Register offsets in adrs[7:0]
`define SPI_ADRS_CTRL      8'h00            // Enable and chip select
`define SPI_ADRS_DIV       8'h04            // SCK divider
`define SPI_ADRS_TXD       8'h08            // Transmit byte, write starts transfer
`define SPI_ADRS_RXD       8'h0C            // Receive byte and busy flag

// --------------------
// SPI core
// --------------------
`define SPI_DIV_WIDTH      16               // Divider register width

// Bit position of busy in the RXD word
`define SPI_RXD_BUSY_BIT   8

`endif
